// File: Bender.yml
package:
  name: mem_sub

dependencies: {}

sources:
  # RTL in compile order.
  - files:
      - common/mem_sub_pkg.sv
      - design/addr_decoder.sv
      - mem_bank/mem_bank.sv
      - design/read_return.sv
      - design/mem_sub_top.sv

  # Verification sources.
  - target: test
    files:
      - dv/mem_sub_assertions.sv
      - dv/mem_sub_tb.sv

// File: common/mem_sub_pkg.sv
package mem_sub_pkg;

	// Upper bound on the number of address regions.
	localparam int MAX_BANKS = 4;

	// Region tags, indexed by bank number.
	// Entry 0 is the low data memory and entry 1 the boot memory.
	localparam logic [11:0] REGION_TAGS [MAX_BANKS] = '{
		12'h000,
		12'hBFC,
		12'h100,
		12'h200
	};

	// Region view of a byte address.
	typedef struct packed {
		logic [11:0] tag;
		logic [17:0] index;
		logic [1:0]  offset;
	} addr_fields_t;

	// One address word, seen as a raw value or as region fields.
	typedef union packed {
		logic [31:0]  raw;
		addr_fields_t field;
	} addr_word_t;

	// Command as presented by the bus master.
	typedef struct packed {
		logic        rd;
		logic        wr;
		addr_word_t  addr;
		logic [31:0] wdata;
		logic [3:0]  be;
	} bus_cmd_t;

	// Request from the decoder to a single bank.
	typedef struct packed {
		logic        valid;
		logic        wr;
		logic [17:0] index;
		logic [31:0] wdata;
		logic [3:0]  be;
	} bank_req_t;

	// Result from a bank, done lasts one cycle.
	typedef struct packed {
		logic        done;
		logic [31:0] rdata;
	} bank_rsp_t;

endpackage

// File: design/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder
	import mem_sub_pkg::*;
#(
	parameter int NUM_BANKS  = 2,
	parameter int BANK_WORDS = 1024
) (
	input  logic      clk,
	input  logic      write,
	input  bus_cmd_t  cmd,
	input  logic      complete,
	output bank_req_t bank_req [NUM_BANKS],
	output logic      local_done,
	output logic      local_err,
	output logic      busy
);

	logic [NUM_BANKS-1:0] tag_hit;
	logic                 in_range;
	logic                 zero_word;
	logic                 accept;
	logic                 to_bank;

	logic [NUM_BANKS-1:0] valid_q;
	logic                 wr_q;
	logic [17:0]          index_q;
	logic [31:0]          wdata_q;
	logic [3:0]           be_q;

	// Local path is two stages deep to line up with a bank access.
	logic                 local_pend;
	logic                 local_pend_err;

	// Match the tag against every populated region.
	always_comb begin
		for (int i = 0; i < NUM_BANKS; i++) begin
			tag_hit[i] = (cmd.addr.field.tag == REGION_TAGS[i]);
		end
	end

	assign in_range = int'(cmd.addr.field.index) < BANK_WORDS;

	// Word 0 of the low region always reads as zero.
	assign zero_word = cmd.rd && (cmd.addr.field.tag == REGION_TAGS[0]) &&
		(cmd.addr.field.index == '0);

	assign accept  = (cmd.rd || cmd.wr) && !busy;
	assign to_bank = (|tag_hit) && in_range && !zero_word;

	always_ff @(posedge clk or posedge write) begin
		if (write) begin
			busy <= 1'b0;
		end else if (accept) begin
			busy <= 1'b1;
		end else if (complete) begin
			busy <= 1'b0;
		end
	end

	// Valid lasts one cycle since busy blocks the next accept.
	always_ff @(posedge clk or posedge write) begin
		if (write) begin
			valid_q <= '0;
		end else if (accept && to_bank) begin
			valid_q <= tag_hit;
		end else begin
			valid_q <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			wr_q    <= cmd.wr;
			index_q <= cmd.addr.field.index;
			wdata_q <= cmd.wdata;
			be_q    <= cmd.be;
		end
	end

	always_ff @(posedge clk or posedge write) begin
		if (write) begin
			local_pend     <= 1'b0;
			local_pend_err <= 1'b0;
			local_done     <= 1'b0;
			local_err      <= 1'b0;
		end else begin
			local_pend     <= accept && !to_bank;
			local_pend_err <= accept && !zero_word && !((|tag_hit) && in_range);
			local_done     <= local_pend;
			local_err      <= local_pend && local_pend_err;
		end
	end

	// Every bank sees the same payload, only valid differs.
	always_comb begin
		for (int i = 0; i < NUM_BANKS; i++) begin
			bank_req[i].valid = valid_q[i];
			bank_req[i].wr    = wr_q;
			bank_req[i].index = index_q;
			bank_req[i].wdata = wdata_q;
			bank_req[i].be    = be_q;
		end
	end

endmodule

// File: design/mem_sub_top.sv
`timescale 1ns/1ps

module mem_sub_top
	import mem_sub_pkg::*;
#(
	parameter int NUM_BANKS  = 2,
	parameter int BANK_WORDS = 1024
) (
	input  logic        clk,
	input  logic        write,

	// Master side of the bus.
	input  logic        rd,
	input  logic        wr,
	input  addr_word_t  addr,
	input  logic [31:0] wdata,
	input  logic [3:0]  be,
	output logic [31:0] readdata,
	output logic        waitrequest,
	output logic        error
);

	bus_cmd_t  cmd;
	bank_req_t bank_req [NUM_BANKS];
	bank_rsp_t bank_rsp [NUM_BANKS];
	logic      local_done;
	logic      local_err;
	logic      busy;
	logic      complete;

	// Bundle the loose bus ports into one command.
	assign cmd.rd    = rd;
	assign cmd.wr    = wr;
	assign cmd.addr  = addr;
	assign cmd.wdata = wdata;
	assign cmd.be    = be;

	addr_decoder #(
		.NUM_BANKS  (NUM_BANKS),
		.BANK_WORDS (BANK_WORDS)
	) u_addr_decoder (
		.clk        (clk),
		.write      (write),
		.cmd        (cmd),
		.complete   (complete),
		.bank_req   (bank_req),
		.local_done (local_done),
		.local_err  (local_err),
		.busy       (busy)
	);

	// One identical bank per mapped region.
	for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
		mem_bank #(
			.BANK_WORDS (BANK_WORDS)
		) u_mem_bank (
			.clk   (clk),
			.write (write),
			.req   (bank_req[g]),
			.rsp   (bank_rsp[g])
		);
	end

	read_return #(
		.NUM_BANKS (NUM_BANKS)
	) u_read_return (
		.rd          (rd),
		.wr          (wr),
		.rsp         (bank_rsp),
		.local_done  (local_done),
		.local_err   (local_err),
		.busy        (busy),
		.readdata    (readdata),
		.waitrequest (waitrequest),
		.error       (error),
		.complete    (complete)
	);

endmodule

// File: design/read_return.sv
`timescale 1ns/1ps

module read_return
	import mem_sub_pkg::*;
#(
	parameter int NUM_BANKS = 2
) (
	input  logic        rd,
	input  logic        wr,
	input  bank_rsp_t   rsp [NUM_BANKS],
	input  logic        local_done,
	input  logic        local_err,
	input  logic        busy,
	output logic [31:0] readdata,
	output logic        waitrequest,
	output logic        error,
	output logic        complete
);

	logic        any_done;
	logic [31:0] bank_data;

	// At most one bank is done in a cycle, so an AND-OR mux is enough.
	always_comb begin
		any_done  = 1'b0;
		bank_data = '0;
		for (int i = 0; i < NUM_BANKS; i++) begin
			any_done  = any_done | rsp[i].done;
			bank_data = bank_data | (rsp[i].done ? rsp[i].rdata : 32'h0);
		end
	end

	assign complete = busy && (any_done || local_done);

	// Local completions return zero data.
	assign readdata = (rd && any_done) ? bank_data : 32'h0;

	// Only an unmapped access flags an error.
	assign error = complete && local_done && local_err;

	// Hold the master until its completion cycle.
	assign waitrequest = (rd || wr) && !complete;

endmodule

// File: dv/mem_sub_assertions.sv
`timescale 1ns/1ps

module mem_sub_assertions (
	input logic        clk,
	input logic        write,
	input logic        rd,
	input logic        wr,
	input logic [31:0] addr,
	input logic [31:0] wdata,
	input logic [3:0]  be,
	input logic        waitrequest,
	input logic        error
);

	int fail_count = 0;

	// Master holds its command until released.
	property p_cmd_stable;
		@(posedge clk) disable iff (write)
		((rd || wr) && waitrequest) |=> $stable({rd, wr, addr, wdata, be});
	endproperty

	property p_rd_wr_exclusive;
		@(posedge clk) disable iff (write)
		!(rd && wr);
	endproperty

	// New command is one after idle or after a completion.
	property p_fixed_latency;
		@(posedge clk) disable iff (write)
		((rd || wr) && (!$past(rd || wr) || !$past(waitrequest)))
			|-> waitrequest ##1 waitrequest ##1 !waitrequest;
	endproperty

	property p_no_error_while_waiting;
		@(posedge clk) disable iff (write)
		waitrequest |-> !error;
	endproperty

	a_cmd_stable: assert property (p_cmd_stable) else begin
		$error("Command changed while waitrequest was high");
		fail_count++;
	end

	a_rd_wr_exclusive: assert property (p_rd_wr_exclusive) else begin
		$error("rd and wr high together");
		fail_count++;
	end

	a_fixed_latency: assert property (p_fixed_latency) else begin
		$error("waitrequest did not fall two cycles after a new command");
		fail_count++;
	end

	a_no_error_while_waiting: assert property (p_no_error_while_waiting) else begin
		$error("error high while waitrequest was high");
		fail_count++;
	end

endmodule

// File: dv/mem_sub_tb.sv
`timescale 1ns/1ps

module mem_sub_tb;

	localparam int NUM_BANKS    = 2;
	localparam int BANK_WORDS   = 1024;
	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 4;

	localparam logic [11:0] LOW_TAG  = 12'h000;
	localparam logic [11:0] BOOT_TAG = 12'hBFC;

	// Command counts per test, used for the watchdog limit.
	localparam int N_BASIC    = 32;
	localparam int N_PARTIAL  = 12;
	localparam int N_ZERO     = 2;
	localparam int N_UNMAPPED = 14;
	localparam int N_POOL     = 32;
	localparam int N_RANDOM   = 300;
	localparam int N_CMDS     = N_BASIC + N_PARTIAL + N_ZERO + N_UNMAPPED + N_POOL + N_RANDOM;

	typedef struct packed {
		logic        rd;
		logic [31:0] addr;
		logic [31:0] data;
		logic        err;
	} expect_t;

	logic        clk;
	logic        write;
	logic        rd;
	logic        wr;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic [3:0]  be;
	logic [31:0] readdata;
	logic        waitrequest;
	logic        error;

	logic [31:0] model_mem [logic [31:0]];
	expect_t     exp_q [$];
	logic [3:0]  be_pat [4] = '{4'b0101, 4'b1010, 4'b0011, 4'b1100};
	integer      seed = 32'he0ca_f430;
	int          data_errors;
	int          flag_errors;
	int          timing_errors;

	mem_sub_top #(
		.NUM_BANKS  (NUM_BANKS),
		.BANK_WORDS (BANK_WORDS)
	) DUT (
		.clk         (clk),
		.write       (write),
		.rd          (rd),
		.wr          (wr),
		.addr        (addr),
		.wdata       (wdata),
		.be          (be),
		.readdata    (readdata),
		.waitrequest (waitrequest),
		.error       (error)
	);

	bind mem_sub_top mem_sub_assertions u_mem_sub_assertions (
		.clk         (clk),
		.write       (write),
		.rd          (rd),
		.wr          (wr),
		.addr        (addr),
		.wdata       (wdata),
		.be          (be),
		.waitrequest (waitrequest),
		.error       (error)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] make_addr(input logic [11:0] tag, input logic [17:0] idx);
		return {tag, idx, 2'b00};
	endfunction

	function automatic logic is_mapped(input logic [31:0] a);
		logic [11:0] tag;
		logic [17:0] idx;
		tag = a[31:20];
		idx = a[19:2];
		return ((tag == LOW_TAG) || (tag == BOOT_TAG)) && (idx < BANK_WORDS);
	endfunction

	// Byte lane merge into the reference memory.
	function automatic void model_write(input logic [31:0] a, input logic [31:0] d,
		input logic [3:0] b);
		logic [31:0] word;
		word = 32'h0;
		if (is_mapped(a)) begin
			if (model_mem.exists(a[31:2])) begin
				word = model_mem[a[31:2]];
			end
			for (int i = 0; i < 4; i++) begin
				if (b[i]) begin
					word[8*i +: 8] = d[8*i +: 8];
				end
			end
			model_mem[a[31:2]] = word;
		end
	endfunction

	function automatic logic [31:0] model_read(input logic [31:0] a);
		if ((a[31:20] == LOW_TAG) && (a[19:2] == '0)) begin
			return 32'h0;
		end
		if (!is_mapped(a) || !model_mem.exists(a[31:2])) begin
			return 32'h0;
		end
		return model_mem[a[31:2]];
	endfunction

	// Waits for the completion edge and checks the fixed latency.
	task automatic wait_complete();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
		end while (waitrequest !== 1'b0);
		assert (cycles == 3) else begin
			timing_errors++;
			$display("[FAIL] %0t waitrequest latency: got %0d cycles, expected 3", $time, cycles);
		end
		@(negedge clk);
		rd = 1'b0;
		wr = 1'b0;
	endtask

	task automatic bus_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] b);
		expect_t e;
		e.rd   = 1'b0;
		e.addr = a;
		e.data = 32'h0;
		e.err  = !is_mapped(a);
		exp_q.push_back(e);
		model_write(a, d, b);
		@(negedge clk);
		rd    = 1'b0;
		wr    = 1'b1;
		addr  = a;
		wdata = d;
		be    = b;
		wait_complete();
	endtask

	task automatic bus_read(input logic [31:0] a);
		expect_t e;
		e.rd   = 1'b1;
		e.addr = a;
		e.data = model_read(a);
		e.err  = !is_mapped(a);
		exp_q.push_back(e);
		@(negedge clk);
		rd   = 1'b1;
		wr   = 1'b0;
		addr = a;
		be   = 4'hF;
		wait_complete();
	endtask

	// Checks every completion against the oldest expected result.
	always @(posedge clk) begin : compare_completion
		expect_t e;
		if (!write && (rd || wr) && (waitrequest === 1'b0)) begin
			e = exp_q.pop_front();
			if (e.rd) begin
				assert (readdata === e.data) else begin
					data_errors++;
					$display("[FAIL] %0t readdata at %08h: got %08h, expected %08h",
						$time, e.addr, readdata, e.data);
				end
			end
			assert (error === e.err) else begin
				flag_errors++;
				$display("[FAIL] %0t error at %08h: got %b, expected %b",
					$time, e.addr, error, e.err);
			end
		end
	end

	initial begin : watchdog
		#((RESET_CYCLES + 200 * N_CMDS) * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display(">>> FAIL");
		$finish;
	end

	initial begin : stimulus
		logic [31:0] r;
		logic [31:0] a;
		int          total;
		clk   = 1'b0;
		write = 1'b1;
		rd    = 1'b0;
		wr    = 1'b0;
		addr  = 32'h0;
		wdata = 32'h0;
		be    = 4'h0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		write = 1'b0;

		// Idle bus after reset.
		repeat (4) begin
			@(posedge clk);
			assert (waitrequest === 1'b0) else begin
				timing_errors++;
				$display("[FAIL] %0t waitrequest while idle: got %b, expected 0",
					$time, waitrequest);
			end
			assert (error === 1'b0) else begin
				flag_errors++;
				$display("[FAIL] %0t error while idle: got %b, expected 0",
					$time, error);
			end
		end

		// Full words in the low and boot regions.
		for (int i = 1; i <= 8; i++) begin
			bus_write(make_addr(LOW_TAG, i), $random(seed), 4'hF);
			bus_read(make_addr(LOW_TAG, i));
		end
		for (int i = 0; i < 8; i++) begin
			bus_write(make_addr(BOOT_TAG, i), $random(seed), 4'hF);
			bus_read(make_addr(BOOT_TAG, i));
		end

		// Partial lane writes.
		for (int i = 0; i < 4; i++) begin
			a = make_addr((i < 2) ? LOW_TAG : BOOT_TAG, 20 + i);
			bus_write(a, 32'h1122_3344, 4'hF);
			bus_write(a, $random(seed), be_pat[i]);
			bus_read(a);
		end

		// Word 0 of the low region.
		bus_write(make_addr(LOW_TAG, 0), 32'hA5A5_5A5A, 4'hF);
		bus_read(make_addr(LOW_TAG, 0));

		// Unmapped tags and out of range indices.
		bus_write(make_addr(12'h100, 1), 32'h0BAD_0001, 4'hF);
		bus_read(make_addr(12'h100, 1));
		bus_write(make_addr(12'h200, 2), 32'h0BAD_0002, 4'hF);
		bus_read(make_addr(12'h200, 2));
		bus_write(make_addr(12'h123, 3), 32'h0BAD_0003, 4'hF);
		bus_read(make_addr(12'h123, 3));
		bus_write(make_addr(LOW_TAG, BANK_WORDS + 1), 32'h0BAD_0004, 4'hF);
		bus_read(make_addr(LOW_TAG, BANK_WORDS + 1));
		bus_write(make_addr(BOOT_TAG, BANK_WORDS + 2), 32'h0BAD_0005, 4'hF);
		bus_read(make_addr(BOOT_TAG, BANK_WORDS + 2));
		bus_read(make_addr(LOW_TAG, 1));
		bus_read(make_addr(LOW_TAG, 2));
		bus_read(make_addr(LOW_TAG, 3));
		bus_read(make_addr(BOOT_TAG, 2));

		// Random mix over a pool that is written first.
		for (int i = 0; i < 16; i++) begin
			bus_write(make_addr(LOW_TAG, i), $random(seed), 4'hF);
			bus_write(make_addr(BOOT_TAG, i), $random(seed), 4'hF);
		end
		for (int n = 0; n < N_RANDOM; n++) begin
			r = $random(seed);
			a = make_addr(r[5] ? BOOT_TAG : LOW_TAG, r[9:6]);
			if (r[4]) begin
				bus_write(a, $random(seed), r[13:10]);
			end else begin
				bus_read(a);
			end
		end

		total = data_errors + flag_errors + timing_errors +
			DUT.u_mem_sub_assertions.fail_count;
		$display("Errors: readdata %0d, error flag %0d, timing %0d, protocol %0d",
			data_errors, flag_errors, timing_errors,
			DUT.u_mem_sub_assertions.fail_count);
		if (total == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// File: mem_bank/mem_bank.sv
`timescale 1ns/1ps

module mem_bank
	import mem_sub_pkg::*;
#(
	parameter int BANK_WORDS = 1024
) (
	input  logic      clk,
	input  logic      write,
	input  bank_req_t req,
	output bank_rsp_t rsp
);

	localparam int IDX_W = $clog2(BANK_WORDS);

	logic [31:0]      mem [BANK_WORDS];
	logic [IDX_W-1:0] idx;
	logic [31:0]      rdata_q;
	logic             done_q;

	// Decoder has already range checked the index.
	assign idx = req.index[IDX_W-1:0];

	// Byte lane writes.
	always_ff @(posedge clk) begin
		if (req.valid && req.wr) begin
			for (int b = 0; b < 4; b++) begin
				if (req.be[b]) begin
					mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
				end
			end
		end
	end

	// Registered read, one cycle after valid.
	always_ff @(posedge clk) begin
		if (req.valid && !req.wr) begin
			rdata_q <= mem[idx];
		end
	end

	always_ff @(posedge clk or posedge write) begin
		if (write) begin
			done_q <= 1'b0;
		end else begin
			done_q <= req.valid;
		end
	end

	assign rsp.done  = done_q;
	assign rsp.rdata = rdata_q;

endmodule

// File: mem_sub.f
common/mem_sub_pkg.sv
design/addr_decoder.sv
mem_bank/mem_bank.sv
design/read_return.sv
design/mem_sub_top.sv
dv/mem_sub_assertions.sv
dv/mem_sub_tb.sv
